//--- rtl/powerCore_macros.svh
`ifndef POWER_CORE_MACROS_SVH
`define POWER_CORE_MACROS_SVH

// data and instruction width
`define WORD_WIDTH 32

// register numbers and file depth
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// instruction memory is word addressed
`define IMEM_ADDR_WIDTH 16

// first fetch address after reset
`define RESET_PC 0

`endif

//--- rtl/powerCorePkg.sv
`default_nettype none

`include "powerCore_macros.svh"

package powerCorePkg;

	// all vectors numbered big-endian, bit 0 is the msb
	typedef logic [0:`WORD_WIDTH-1] word_t;
	typedef logic [0:`REG_ADDR_WIDTH-1] regAddr_t;
	typedef logic [0:`IMEM_ADDR_WIDTH-1] instrAddr_t;
	typedef logic [0:5] opcode_t;
	typedef logic [0:9] xOpcode_t;

	// operations understood by the fixed point unit
	typedef enum logic [2:0] {
		FX_ADD,
		FX_SUBF,
		FX_AND,
		FX_OR,
		FX_XOR,
		FX_BRANCH,
		FX_NONE
	} fxOp_t;

	typedef enum logic {
		BUS_IDLE,
		BUS_WAIT_ACK
	} busState_t;

	typedef enum logic [1:0] {
		FETCH_REQUEST,
		FETCH_WAIT_INSTR,
		FETCH_WAIT_RETIRE
	} fetchState_t;

endpackage

`default_nettype wire

//--- rtl/instrBusMaster.sv
`default_nettype none

module instrBusMaster (
	input wire clock_i,
	input wire reset_i,
	input wire fetchReq_i,
	input wire powerCorePkg::instrAddr_t fetchAddr_i,
	output logic instrValid_o,
	output powerCorePkg::word_t instrWord_o,
	output logic wbCyc_o,
	output logic wbStb_o,
	output powerCorePkg::instrAddr_t wbAdr_o,
	input wire powerCorePkg::word_t wbDat_i,
	input wire wbAck_i
);
	import powerCorePkg::*;

	busState_t state;

	// control path
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			state <= BUS_IDLE;
			wbCyc_o <= 1'b0;
			wbStb_o <= 1'b0;
			instrValid_o <= 1'b0;
		end
		else
		begin
			instrValid_o <= 1'b0;
			case (state)
				BUS_IDLE:
				begin
					if (fetchReq_i)
					begin
						wbCyc_o <= 1'b1;
						wbStb_o <= 1'b1;
						state <= BUS_WAIT_ACK;
					end
				end
				BUS_WAIT_ACK:
				begin
					// cycle ends on the ack edge
					if (wbAck_i)
					begin
						wbCyc_o <= 1'b0;
						wbStb_o <= 1'b0;
						instrValid_o <= 1'b1;
						state <= BUS_IDLE;
					end
				end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	// address latched with the request, data with the ack
	always_ff @(posedge clock_i)
	begin
		if (state == BUS_IDLE && fetchReq_i)
			wbAdr_o <= fetchAddr_i;
		if (state == BUS_WAIT_ACK && wbAck_i)
			instrWord_o <= wbDat_i;
	end

	//////////////////////////////////////////////////////////////////////
	// bus protocol checks
	//////////////////////////////////////////////////////////////////////

	// an unanswered strobe stays up, and always inside a cycle
	stbHeldInCycle: assert property (@(posedge clock_i) disable iff (reset_i)
		wbStb_o && !wbAck_i |=> wbStb_o && wbCyc_o);

	adrStableWhileWaiting: assert property (@(posedge clock_i) disable iff (reset_i)
		state == BUS_WAIT_ACK && !wbAck_i |=> $stable(wbAdr_o));

endmodule

`default_nettype wire

//--- rtl/fetchUnit.sv
`default_nettype none

`include "powerCore_macros.svh"

module fetchUnit (
	input wire clock_i,
	input wire reset_i,
	input wire retire_i,
	input wire redirect_i,
	input wire powerCorePkg::instrAddr_t target_i,
	output logic fetchReq_o,
	output powerCorePkg::instrAddr_t fetchAddr_o,
	input wire instrValid_i,
	input wire powerCorePkg::word_t instrWord_i,
	output logic decodeValid_o,
	output powerCorePkg::word_t decodeWord_o,
	output powerCorePkg::instrAddr_t decodePc_o
);
	import powerCorePkg::*;

	fetchState_t state;
	instrAddr_t pc;

	// one request per instruction, issued from the request state
	assign fetchReq_o = (state == FETCH_REQUEST);
	assign fetchAddr_o = pc;

	// returned word goes straight on to decode with its address
	assign decodeValid_o = instrValid_i && (state == FETCH_WAIT_INSTR);
	assign decodeWord_o = instrWord_i;
	assign decodePc_o = pc;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			state <= FETCH_REQUEST;
			pc <= instrAddr_t'(`RESET_PC);
		end
		else
		begin
			case (state)
				FETCH_REQUEST: state <= FETCH_WAIT_INSTR;
				FETCH_WAIT_INSTR:
				begin
					if (instrValid_i)
						state <= FETCH_WAIT_RETIRE;
				end
				FETCH_WAIT_RETIRE:
				begin
					// next pc only known once the instruction retires
					if (retire_i)
					begin
						pc <= redirect_i ? target_i : pc + 1'b1;
						state <= FETCH_REQUEST;
					end
				end
				default: state <= FETCH_REQUEST;
			endcase
		end
	end

	// one instruction in flight
	noReqWhileWaiting: assert property (@(posedge clock_i) disable iff (reset_i)
		state == FETCH_WAIT_RETIRE && !retire_i |=> !fetchReq_o);

	retireOnlyWhenWaiting: assert property (@(posedge clock_i) disable iff (reset_i)
		retire_i |-> state == FETCH_WAIT_RETIRE);

endmodule

`default_nettype wire

//--- rtl/decodeUnit.sv
`default_nettype none

module decodeUnit (
	input wire clock_i,
	input wire reset_i,
	input wire valid_i,
	input wire powerCorePkg::word_t instr_i,
	input wire powerCorePkg::instrAddr_t pc_i,
	output logic valid_o,
	output powerCorePkg::fxOp_t op_o,
	output powerCorePkg::regAddr_t dest_o,
	output powerCorePkg::regAddr_t ra_o,
	output powerCorePkg::regAddr_t rb_o,
	output powerCorePkg::word_t imm_o,
	output logic useImm_o,
	output logic raIsZero_o,
	output logic writeEnable_o,
	output powerCorePkg::instrAddr_t pc_o
);
	import powerCorePkg::*;

	// primary opcodes
	localparam opcode_t OP_ADDI = 6'd14;
	localparam opcode_t OP_ADDIS = 6'd15;
	localparam opcode_t OP_B = 6'd18;
	localparam opcode_t OP_ORI = 6'd24;
	localparam opcode_t OP_ORIS = 6'd25;
	localparam opcode_t OP_XORI = 6'd26;
	localparam opcode_t OP_ANDI = 6'd28;
	localparam opcode_t OP_XFORM = 6'd31;

	// extended opcodes under 31
	localparam xOpcode_t XO_ADD = 10'd266;
	localparam xOpcode_t XO_SUBF = 10'd40;
	localparam xOpcode_t XO_AND = 10'd28;
	localparam xOpcode_t XO_OR = 10'd444;
	localparam xOpcode_t XO_XOR = 10'd316;

	opcode_t opcode;
	xOpcode_t xOpcode;
	regAddr_t rtField;
	regAddr_t raField;
	regAddr_t rbField;
	fxOp_t opNext;
	regAddr_t destNext;
	regAddr_t raNext;
	word_t immNext;
	logic useImmNext;
	logic raIsZeroNext;

	assign opcode = instr_i[0:5];
	assign rtField = instr_i[6:10];
	assign raField = instr_i[11:15];
	assign rbField = instr_i[16:20];
	assign xOpcode = instr_i[21:30];

	always_comb
	begin
		opNext = FX_NONE;
		destNext = rtField;
		raNext = raField;
		immNext = {{16{instr_i[16]}}, instr_i[16:31]};
		useImmNext = 1'b1;
		raIsZeroNext = 1'b0;
		case (opcode)
			OP_ADDI, OP_ADDIS:
			begin
				opNext = FX_ADD;
				raIsZeroNext = (raField == '0);
				if (opcode == OP_ADDIS)
					immNext = {instr_i[16:31], 16'h0000};
			end
			OP_ORI, OP_ORIS, OP_XORI, OP_ANDI:
			begin
				// logical D-form writes rA from rS
				destNext = raField;
				raNext = rtField;
				immNext = {16'h0000, instr_i[16:31]};
				if (opcode == OP_ORIS)
					immNext = {instr_i[16:31], 16'h0000};
				case (opcode)
					OP_XORI: opNext = FX_XOR;
					OP_ANDI: opNext = FX_AND;
					default: opNext = FX_OR;
				endcase
			end
			OP_B:
			begin
				// relative, no link; LI is already a word offset
				if (!instr_i[30] && !instr_i[31])
					opNext = FX_BRANCH;
				immNext = {{8{instr_i[6]}}, instr_i[6:29]};
				raIsZeroNext = 1'b1;
			end
			OP_XFORM:
			begin
				useImmNext = 1'b0;
				case (xOpcode)
					XO_ADD: opNext = FX_ADD;
					XO_SUBF: opNext = FX_SUBF;
					XO_AND: opNext = FX_AND;
					XO_OR: opNext = FX_OR;
					XO_XOR: opNext = FX_XOR;
					default: opNext = FX_NONE;
				endcase
				if (xOpcode == XO_AND || xOpcode == XO_OR || xOpcode == XO_XOR)
				begin
					destNext = raField;
					raNext = rtField;
				end
			end
			default: opNext = FX_NONE;
		endcase
	end

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	always_ff @(posedge clock_i)
	begin
		if (valid_i)
		begin
			op_o <= opNext;
			dest_o <= destNext;
			ra_o <= raNext;
			rb_o <= rbField;
			imm_o <= immNext;
			useImm_o <= useImmNext;
			raIsZero_o <= raIsZeroNext;
			// branches and unknown encodings write nothing
			writeEnable_o <= (opNext != FX_NONE) && (opNext != FX_BRANCH);
			pc_o <= pc_i;
		end
	end

endmodule

`default_nettype wire

//--- rtl/registerUnit.sv
`default_nettype none

`include "powerCore_macros.svh"

module registerUnit (
	input wire clock_i,
	input wire reset_i,
	input wire valid_i,
	input wire powerCorePkg::fxOp_t op_i,
	input wire powerCorePkg::regAddr_t dest_i,
	input wire powerCorePkg::regAddr_t ra_i,
	input wire powerCorePkg::regAddr_t rb_i,
	input wire powerCorePkg::word_t imm_i,
	input wire useImm_i,
	input wire raIsZero_i,
	input wire writeEnable_i,
	input wire powerCorePkg::instrAddr_t pc_i,
	input wire wbEnable_i,
	input wire powerCorePkg::regAddr_t wbAddr_i,
	input wire powerCorePkg::word_t wbData_i,
	input wire powerCorePkg::regAddr_t debugAddr_i,
	output powerCorePkg::word_t debugData_o,
	output logic valid_o,
	output powerCorePkg::fxOp_t op_o,
	output powerCorePkg::word_t operandA_o,
	output powerCorePkg::word_t operandB_o,
	output powerCorePkg::regAddr_t dest_o,
	output logic writeEnable_o,
	output powerCorePkg::instrAddr_t pc_o
);
	import powerCorePkg::*;

	word_t regFile [0:`REG_COUNT-1];

	//////////////////////////////////////////////////////////////////////
	// register array with writeback
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regFile[i] <= '0;
		end
		else if (wbEnable_i)
			regFile[wbAddr_i] <= wbData_i;
	end

	// debug port sees the array directly
	assign debugData_o = regFile[debugAddr_i];

	//////////////////////////////////////////////////////////////////////
	// operand read stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			valid_o <= 1'b0;
		else
			valid_o <= valid_i;
	end

	always_ff @(posedge clock_i)
	begin
		if (valid_i)
		begin
			// rA of 0 reads as zero for addi, addis and b
			operandA_o <= raIsZero_i ? '0 : regFile[ra_i];
			operandB_o <= useImm_i ? imm_i : regFile[rb_i];
			op_o <= op_i;
			dest_o <= dest_i;
			writeEnable_o <= writeEnable_i;
			pc_o <= pc_i;
		end
	end

endmodule

`default_nettype wire

//--- rtl/fixedPointUnit.sv
`default_nettype none

`include "powerCore_macros.svh"

module fixedPointUnit (
	input wire clock_i,
	input wire reset_i,
	input wire valid_i,
	input wire powerCorePkg::fxOp_t op_i,
	input wire powerCorePkg::word_t operandA_i,
	input wire powerCorePkg::word_t operandB_i,
	input wire powerCorePkg::regAddr_t dest_i,
	input wire writeEnable_i,
	input wire powerCorePkg::instrAddr_t pc_i,
	output logic wbEnable_o,
	output powerCorePkg::regAddr_t wbAddr_o,
	output powerCorePkg::word_t wbData_o,
	output logic retire_o,
	output powerCorePkg::instrAddr_t retirePc_o,
	output logic redirect_o,
	output powerCorePkg::instrAddr_t target_o
);
	import powerCorePkg::*;

	word_t result;
	word_t branchSum;

	always_comb
	begin
		case (op_i)
			FX_ADD: result = operandA_i + operandB_i;
			// subf is rB minus rA
			FX_SUBF: result = operandB_i - operandA_i;
			FX_AND: result = operandA_i & operandB_i;
			FX_OR: result = operandA_i | operandB_i;
			FX_XOR: result = operandA_i ^ operandB_i;
			default: result = '0;
		endcase
	end

	// word offset added to the word address of the branch
	assign branchSum = word_t'(pc_i) + operandB_i;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			wbEnable_o <= 1'b0;
			retire_o <= 1'b0;
			redirect_o <= 1'b0;
		end
		else
		begin
			wbEnable_o <= valid_i && writeEnable_i;
			retire_o <= valid_i;
			redirect_o <= valid_i && (op_i == FX_BRANCH);
		end
	end

	always_ff @(posedge clock_i)
	begin
		if (valid_i)
		begin
			wbAddr_o <= dest_i;
			wbData_o <= result;
			retirePc_o <= pc_i;
			target_o <= branchSum[`WORD_WIDTH-`IMEM_ADDR_WIDTH:`WORD_WIDTH-1];
		end
	end

	redirectOnlyOnRetire: assert property (@(posedge clock_i) disable iff (reset_i)
		redirect_o |-> retire_o);

	// with one instruction in flight retires never come back to back
	retireIsolated: assert property (@(posedge clock_i) disable iff (reset_i)
		retire_o |=> !retire_o);

endmodule

`default_nettype wire

//--- rtl/powerCore.sv
`default_nettype none

module powerCore (
	input wire clock_i,
	input wire reset_i,
	output logic wbCyc_o,
	output logic wbStb_o,
	output powerCorePkg::instrAddr_t wbAdr_o,
	input wire powerCorePkg::word_t wbDat_i,
	input wire wbAck_i,
	input wire powerCorePkg::regAddr_t debugAddr_i,
	output powerCorePkg::word_t debugData_o,
	output logic retire_o,
	output powerCorePkg::instrAddr_t retirePc_o
);
	import powerCorePkg::*;

	// fetch and bus
	logic fetchReq;
	instrAddr_t fetchAddr;
	logic instrValid;
	word_t instrWord;
	logic redirect;
	instrAddr_t target;

	// fetch to decode
	logic decodeValid;
	word_t decodeWord;
	instrAddr_t decodePc;

	// decode to register read
	logic decValid;
	fxOp_t decOp;
	regAddr_t decDest;
	regAddr_t decRa;
	regAddr_t decRb;
	word_t decImm;
	logic decUseImm;
	logic decRaIsZero;
	logic decWriteEnable;
	instrAddr_t decPc;

	// register read to execute
	logic opValid;
	fxOp_t opOp;
	word_t operandA;
	word_t operandB;
	regAddr_t opDest;
	logic opWriteEnable;
	instrAddr_t opPc;

	// writeback
	logic wbEnable;
	regAddr_t wbAddr;
	word_t wbData;

	instrBusMaster u_instrBusMaster (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.fetchReq_i(fetchReq),
		.fetchAddr_i(fetchAddr),
		.instrValid_o(instrValid),
		.instrWord_o(instrWord),
		.wbCyc_o(wbCyc_o),
		.wbStb_o(wbStb_o),
		.wbAdr_o(wbAdr_o),
		.wbDat_i(wbDat_i),
		.wbAck_i(wbAck_i)
	);

	fetchUnit u_fetchUnit (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.retire_i(retire_o),
		.redirect_i(redirect),
		.target_i(target),
		.fetchReq_o(fetchReq),
		.fetchAddr_o(fetchAddr),
		.instrValid_i(instrValid),
		.instrWord_i(instrWord),
		.decodeValid_o(decodeValid),
		.decodeWord_o(decodeWord),
		.decodePc_o(decodePc)
	);

	decodeUnit u_decodeUnit (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.valid_i(decodeValid),
		.instr_i(decodeWord),
		.pc_i(decodePc),
		.valid_o(decValid),
		.op_o(decOp),
		.dest_o(decDest),
		.ra_o(decRa),
		.rb_o(decRb),
		.imm_o(decImm),
		.useImm_o(decUseImm),
		.raIsZero_o(decRaIsZero),
		.writeEnable_o(decWriteEnable),
		.pc_o(decPc)
	);

	registerUnit u_registerUnit (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.valid_i(decValid),
		.op_i(decOp),
		.dest_i(decDest),
		.ra_i(decRa),
		.rb_i(decRb),
		.imm_i(decImm),
		.useImm_i(decUseImm),
		.raIsZero_i(decRaIsZero),
		.writeEnable_i(decWriteEnable),
		.pc_i(decPc),
		.wbEnable_i(wbEnable),
		.wbAddr_i(wbAddr),
		.wbData_i(wbData),
		.debugAddr_i(debugAddr_i),
		.debugData_o(debugData_o),
		.valid_o(opValid),
		.op_o(opOp),
		.operandA_o(operandA),
		.operandB_o(operandB),
		.dest_o(opDest),
		.writeEnable_o(opWriteEnable),
		.pc_o(opPc)
	);

	fixedPointUnit u_fixedPointUnit (
		.clock_i(clock_i),
		.reset_i(reset_i),
		.valid_i(opValid),
		.op_i(opOp),
		.operandA_i(operandA),
		.operandB_i(operandB),
		.dest_i(opDest),
		.writeEnable_i(opWriteEnable),
		.pc_i(opPc),
		.wbEnable_o(wbEnable),
		.wbAddr_o(wbAddr),
		.wbData_o(wbData),
		.retire_o(retire_o),
		.retirePc_o(retirePc_o),
		.redirect_o(redirect),
		.target_o(target)
	);

endmodule

`default_nettype wire

//--- tests/powerCoreTb.sv
`default_nettype none

`include "powerCore_macros.svh"

module powerCoreTb;
	timeunit 1ns;
	timeprecision 10ps;

	localparam int CLOCK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int DATA_DEPTH = 256;
	localparam int WORST_CYCLES = 9;
	localparam int START_MARGIN = 20;
	// b with a zero offset, what memory returns past the image
	localparam logic [31:0] SELF_BRANCH = 32'h4800_0000;

	logic clock;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic [15:0] wbAdr;
	logic [31:0] wbDat;
	logic wbAck;
	logic [4:0] debugAddr;
	logic [31:0] debugData;
	logic retire;
	logic [15:0] retirePc;

	// length, program image, retire count, then r0..r31
	logic [31:0] testData [0:DATA_DEPTH-1];
	int programLength;
	int expectedRetires;
	int retireCount;
	int cycleCount;
	int cycleLimit;
	logic [31:0] lfsrState;

	// memory model and pc model state
	logic [15:0] modelPc;
	logic [15:0] reqAddr;
	int waitLeft;
	logic busActive;
	logic ackDriven;
	logic fetchPending;
	logic [31:0] fetchedWord;

	powerCore u_powerCore (
		.clock_i(clock),
		.reset_i(reset),
		.wbCyc_o(wbCyc),
		.wbStb_o(wbStb),
		.wbAdr_o(wbAdr),
		.wbDat_i(wbDat),
		.wbAck_i(wbAck),
		.debugAddr_i(debugAddr),
		.debugData_o(debugData),
		.retire_o(retire),
		.retirePc_o(retirePc)
	);

	initial
		clock = 1'b0;

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "stopping at the first error");
		end
	endtask

	// taps 32, 22, 2, 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// two bits, so 0 to 3 wait cycles
	function automatic int drawWaitStates();
		int waits;
		waits = 0;
		for (int i = 0; i < 2; i++)
		begin
			lfsrState = stepLfsr(lfsrState);
			waits = (waits << 1) | int'(lfsrState[0]);
		end
		return waits;
	endfunction

	function automatic logic [31:0] readWord(input logic [15:0] addr);
		if (int'(addr) < programLength)
			return testData[1 + int'(addr)];
		return SELF_BRANCH;
	endfunction

	// sign bits of LI above bit 15 drop out of a 16-bit word address sum
	function automatic logic [15:0] nextPc(input logic [15:0] pc, input logic [31:0] word);
		logic [15:0] offset;
		offset = word[17:2];
		if (word[31:26] == 6'd18 && word[1:0] == 2'b00)
			return pc + offset;
		return pc + 16'd1;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// wishbone memory and retire tracking
	//////////////////////////////////////////////////////////////////////

	task automatic serviceBus();
		if (ackDriven)
		begin
			// ack was sampled at this edge
			wbAck = 1'b0;
			ackDriven = 1'b0;
			busActive = 1'b0;
			checkValue(wbCyc, 1'b0, "cyc still high after the ack edge");
			fetchPending = 1'b1;
		end
		else
		begin
			if (!busActive && wbCyc)
			begin
				busActive = 1'b1;
				reqAddr = wbAdr;
				waitLeft = drawWaitStates();
				checkValue(fetchPending, 1'b0, "fetch issued with an instruction in flight");
				checkValue(reqAddr, modelPc, "fetch address");
			end
			if (busActive)
			begin
				checkValue(wbCyc, 1'b1, "cyc dropped before ack");
				checkValue(wbStb, 1'b1, "stb dropped before ack");
				checkValue(wbAdr, reqAddr, "address changed before ack");
				if (waitLeft == 0)
				begin
					wbDat = readWord(reqAddr);
					fetchedWord = wbDat;
					wbAck = 1'b1;
					ackDriven = 1'b1;
				end
				else
					waitLeft--;
			end
		end
	endtask

	task automatic watchRetire();
		if (retire)
		begin
			checkValue(fetchPending, 1'b1, "retire without an acknowledged fetch");
			checkValue(retirePc, modelPc, "retire address");
			fetchPending = 1'b0;
			modelPc = nextPc(modelPc, fetchedWord);
			retireCount++;
		end
	endtask

	task automatic clearedRegisterCheck();
		for (int i = 0; i < 32; i++)
		begin
			debugAddr = 5'(i);
			#0.25;
			checkValue(debugData, 32'h0, $sformatf("r%0d after reset", i));
		end
	endtask

	task automatic finalRegisterCheck();
		for (int i = 0; i < 32; i++)
		begin
			debugAddr = 5'(i);
			#1;
			checkValue(debugData, testData[2 + programLength + i],
				$sformatf("r%0d final value", i));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		reset = 1'b1;
		wbAck = 1'b0;
		wbDat = 32'h0;
		debugAddr = 5'd0;
		lfsrState = 32'h7e75;
		modelPc = 16'(`RESET_PC);
		reqAddr = 16'h0;
		waitLeft = 0;
		busActive = 1'b0;
		ackDriven = 1'b0;
		fetchPending = 1'b0;
		fetchedWord = 32'h0;
		retireCount = 0;
		cycleCount = 0;

		$readmemh("tests/powerCore_tests.dat", testData);
		if ($isunknown(testData[0]) || testData[0] == 0 || testData[0] > DATA_DEPTH - 34)
		begin
			$display("the test data file is missing or has no program length");
			$display("Result: FAILED");
			$fatal(1, "no usable test data");
		end
		programLength = int'(testData[0]);
		expectedRetires = int'(testData[1 + programLength]);
		cycleLimit = expectedRetires * WORST_CYCLES + START_MARGIN;

		// register file is cleared from the first reset edge on
		fork
			begin
				repeat (RESET_CYCLES) @(posedge clock);
				#1;
			end
			begin
				@(posedge clock);
				#1;
				clearedRegisterCheck();
			end
		join
		reset = 1'b0;
		checkValue(retire, 1'b0, "retire after reset");
		checkValue(wbCyc, 1'b0, "cyc after reset");
		checkValue(wbStb, 1'b0, "stb after reset");

		while (retireCount < expectedRetires && cycleCount < cycleLimit)
		begin
			@(posedge clock);
			#1;
			cycleCount++;
			checkValue(wbStb & ~wbCyc, 1'b0, "stb high outside a bus cycle");
			serviceBus();
			watchRetire();
		end

		if (retireCount < expectedRetires)
		begin
			$display("timeout: %0d of %0d instructions retired within %0d cycles",
				retireCount, expectedRetires, cycleLimit);
			$display("Result: FAILED");
			$fatal(1, "run did not complete");
		end
		else
		begin
			// last write lands one edge after its retire
			@(posedge clock);
			#1;
			finalRegisterCheck();
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- tests/powerCore_tests.dat
// program length, then one instruction word per line
// then the retire count, then expected r0..r31 four per line
00000013
3820FFFB // addi r1, r0, -5
3C401234 // addis r2, r0, 0x1234
60425678 // ori r2, r2, 0x5678
6443A000 // oris r3, r2, 0xa000
682400FF // xori r4, r1, 0x00ff
70258F0F // andi r5, r1, 0x8f0f
38C2FFF0 // addi r6, r2, -16
7CE20A14 // add r7, r2, r1
7D011050 // subf r8, r1, r2
7C692038 // and r9, r3, r4
7CAA3378 // or r10, r5, r6
7CEB4278 // xor r11, r7, r8
38000077 // addi r0, r0, 0x77
39800100 // addi r12, r0, 0x100 reads zero for rA
4800000C // b +3
39A00001 // addi r13, r0, 1 skipped
39C00002 // addi r14, r0, 2 skipped
7DE06214 // add r15, r0, r12
00000000 // unknown encoding, retires as no-op
// retire count
00000011
// r0..r31
00000077 FFFFFFFB 12345678 B2345678
FFFFFF04 00008F0B 12345668 12345673
1234567D B2345600 1234DF6B 0000000E
00000100 00000000 00000000 00000177
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000

//--- sim.f
+incdir+rtl
rtl/powerCorePkg.sv
rtl/instrBusMaster.sv
rtl/fetchUnit.sv
rtl/decodeUnit.sv
rtl/registerUnit.sv
rtl/fixedPointUnit.sv
rtl/powerCore.sv
tests/powerCoreTb.sv

//--- run.sh
#!/bin/sh
# builds the powerCore testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module powerCoreTb -f sim.f -o powerCoreSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/powerCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
